// ==== files.f ====
+incdir+src
src/tamago_core_pkg.sv
src/tamago_bus_pkg.sv
src/bridge_settings.sv
src/cpu_tick_gen.sv
src/rom_image.sv
src/core_port.sv
src/tamago_core_top.sv
sim/tamago_props.sv
sim/tamago_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tamago core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tamago_tb \
  -f files.f -Mdir obj_dir -o tamago_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tamago_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
if grep -q "\*\* FAIL \*\*" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== sim/tamago_tb.sv ====
// tamago control core testbench
// register readback, ROM load, halt, mute and turbo cancel over AXI4-Lite
// tick timing is watched by the bound properties

`timescale 1ns/10ps
`include "tamago_settings.svh"

module tamago_tb;

  // about 8000 cycles of tests, ticks at most 401 apart
  localparam int timeout_cycles = 20000;

  logic clk_32_768 = 1'b0;
  logic reset_turbo_s;
  tamago_bus_pkg::axil_req_t axil_req;
  tamago_bus_pkg::axil_rsp_t axil_rsp;
  logic buzzer;
  logic halt;
  logic [`TAMAGO_ROM_AW-1:0] rom_addr;
  logic clk_en;
  logic clk_2x_en;
  logic [11:0] rom_data;
  logic [`TAMAGO_AUDIO_W-1:0] audio_level;
  logic [31:0] lfsr_state = 32'h9052_c829;
  int cycle_count = 0;

  tamago_core_top i_tamago_core_top (
    .clk_32_768    (clk_32_768),
    .reset_turbo_s (reset_turbo_s),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .buzzer        (buzzer),
    .halt          (halt),
    .rom_addr      (rom_addr),
    .clk_en        (clk_en),
    .clk_2x_en     (clk_2x_en),
    .rom_data      (rom_data),
    .audio_level   (audio_level)
  );

  always #2 clk_32_768 = ~clk_32_768;

  always @(posedge clk_32_768) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("** FAIL **");
      $fatal(1, "run timed out");
    end
  end

  always @(negedge clk_32_768) begin
    if (i_tamago_core_top.i_tamago_props.fail_count != 0) begin
      $display("a bound property on the DUT failed");
      $display("** FAIL **");
      $fatal(1, "property failure");
    end
  end

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("FAIL %s expected 0x%0h actual 0x%0h", test, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value check failed");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////
  // AXI4-Lite master

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_32_768);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    @(negedge clk_32_768);
    while (!axil_rsp.awready) begin
      @(negedge clk_32_768);
    end
    check_value("write ready", 32'h1, 32'(axil_rsp.wready));
    @(posedge clk_32_768);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk_32_768);
    while (!axil_rsp.bvalid) begin
      @(negedge clk_32_768);
    end
    check_value("write response", 32'h0, 32'(axil_rsp.bresp));
    // bready is high, response taken here
    @(posedge clk_32_768);
  endtask

  task automatic read_expect(input string test, input logic [31:0] addr,
                             input logic [31:0] expected);
    @(posedge clk_32_768);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    @(negedge clk_32_768);
    while (!axil_rsp.arready) begin
      @(negedge clk_32_768);
    end
    @(posedge clk_32_768);
    axil_req.arvalid <= 1'b0;
    @(negedge clk_32_768);
    while (!axil_rsp.rvalid) begin
      @(negedge clk_32_768);
    end
    check_value({test, " rresp"}, 32'h0, 32'(axil_rsp.rresp));
    check_value(test, expected, axil_rsp.rdata);
    @(posedge clk_32_768);
  endtask

  task automatic wait_ticks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk_32_768);
      if (clk_en) begin
        seen++;
      end
    end
  endtask

  task automatic pulse_buzzer();
    @(posedge clk_32_768);
    buzzer <= 1'b1;
    @(posedge clk_32_768);
    buzzer <= 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [15:0] word;
    logic [15:0] addr_bits;
    logic [15:0] swapped;
    logic [11:0] held;

    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    reset_turbo_s   = 1'b1;
    buzzer          = 1'b0;
    halt            = 1'b0;
    rom_addr        = '0;
    repeat (5) @(posedge clk_32_768);
    reset_turbo_s <= 1'b0;

    // 1x after reset, then every other speed held for a few ticks
    wait_ticks(3);
    read_expect("speed after reset", `TAMAGO_REG_TURBO, 32'h0);
    for (int s = 1; s < 4; s++) begin
      axil_write(`TAMAGO_REG_TURBO, 32'(s));
      read_expect("speed readback", `TAMAGO_REG_TURBO, 32'(s));
      wait_ticks(4);
    end
    read_expect("unmapped read", 32'h0000_0200, 32'h0);
    read_expect("sound register read", `TAMAGO_REG_SOUND, 32'h0);

    // ROM load at 50x
    axil_write(`TAMAGO_REG_TURBO, 32'd2);
    for (int i = 0; i < 16; i++) begin
      random_bits(13, addr_bits);
      random_bits(16, word);
      axil_write(`TAMAGO_ROM_BASE | (32'(addr_bits[12:0]) << 1), {16'h0, word});
      @(posedge clk_32_768);
      rom_addr <= addr_bits[12:0];
      // one cycle for the registered read
      @(posedge clk_32_768);
      wait_ticks(1);
      @(negedge clk_32_768);
      swapped = {word[7:0], word[15:8]};
      check_value("rom load", 32'(swapped[11:0]), 32'(rom_data));
    end

    // distinct word at the next address
    axil_write(`TAMAGO_ROM_BASE | (32'(rom_addr + 13'd1) << 1), {16'h0, ~word});

    // halt, new address must not reach rom_data
    @(posedge clk_32_768);
    halt <= 1'b1;
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    held = rom_data;
    @(posedge clk_32_768);
    rom_addr <= rom_addr + 13'd1;
    repeat (40) @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_value("rom data while halted", 32'(held), 32'(rom_data));
    @(posedge clk_32_768);
    halt <= 1'b0;

    // buzzer level, unmuted then muted
    axil_write(`TAMAGO_REG_SOUND, 32'h0);
    @(posedge clk_32_768);
    buzzer <= 1'b1;
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_value("audio unmuted", 32'(`TAMAGO_AUDIO_ON), 32'(audio_level));
    @(posedge clk_32_768);
    buzzer <= 1'b0;
    axil_write(`TAMAGO_REG_SOUND, 32'h1);
    @(posedge clk_32_768);
    buzzer <= 1'b1;
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_value("audio muted", 32'h0, 32'(audio_level));
    @(posedge clk_32_768);
    buzzer <= 1'b0;

    // turbo cancel on and off
    axil_write(`TAMAGO_REG_CANCEL, 32'h1);
    axil_write(`TAMAGO_REG_TURBO, 32'd2);
    read_expect("speed before buzzer", `TAMAGO_REG_TURBO, 32'd2);
    pulse_buzzer();
    read_expect("speed after cancel", `TAMAGO_REG_TURBO, 32'h0);
    axil_write(`TAMAGO_REG_CANCEL, 32'h0);
    axil_write(`TAMAGO_REG_TURBO, 32'd2);
    pulse_buzzer();
    read_expect("speed with cancel off", `TAMAGO_REG_TURBO, 32'd2);

    repeat (20) @(posedge clk_32_768);
    if (i_tamago_core_top.i_tamago_props.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("a bound property on the DUT failed");
      $display("** FAIL **");
      $fatal(1, "property failure");
    end
  end

endmodule

// ==== sim/tamago_props.sv ====
// tamago core properties
// tick spacing per turbo speed, 2x tick placement and halt gating

`timescale 1ns/10ps

module tamago_props (
  input logic                          clk_32_768,
  input logic                          reset_turbo_s,
  input logic                          halt,
  input logic                          clk_en,
  input logic                          clk_2x_en,
  input logic [11:0]                   rom_data,
  input logic                          tick,
  input logic                          tick_2x,
  input tamago_core_pkg::turbo_speed_t speed
);

  int fail_count = 0;
  logic [11:0] gap;
  logic [11:0] stable_run;
  logic [3:0]  half_seen;
  logic        seen_tick;
  logic        spacing_valid;
  tamago_core_pkg::turbo_speed_t speed_q;

  // tick spacing per speed, reload + 1
  function automatic logic [11:0] expected_gap(input tamago_core_pkg::turbo_speed_t s);
    case (s)
      tamago_core_pkg::SPEED_1X: return 12'd401;
      tamago_core_pkg::SPEED_4X: return 12'd101;
      default:                   return 12'd9;
    endcase
  endfunction

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      gap        <= '0;
      stable_run <= '0;
      half_seen  <= '0;
      seen_tick  <= 1'b0;
      speed_q    <= tamago_core_pkg::SPEED_1X;
    end else begin
      speed_q <= speed;
      if (speed != speed_q) begin
        stable_run <= '0;
      end else if (stable_run != '1) begin
        stable_run <= stable_run + 12'd1;
      end
      if (tick) begin
        gap       <= 12'd1;
        half_seen <= '0;
        seen_tick <= 1'b1;
      end else begin
        gap <= gap + 12'd1;
        if (tick_2x) begin
          half_seen <= half_seen + 4'd1;
        end
      end
    end
  end

  // speed held since before the previous reload
  assign spacing_valid = tick && seen_tick && (stable_run > gap + 12'd4);

  ////////////////////////////////////////////////////
  // properties

  a_tick_spacing: assert property (@(posedge clk_32_768) disable iff (reset_turbo_s)
    spacing_valid |-> gap == expected_gap(speed))
    else begin
      fail_count++;
      $error("tick spacing does not match the turbo speed");
    end

  a_half_tick_between: assert property (@(posedge clk_32_768) disable iff (reset_turbo_s)
    spacing_valid |-> half_seen == 4'd1)
    else begin
      fail_count++;
      $error("expected exactly one 2x tick between two 1x ticks");
    end

  a_half_tick_with_tick: assert property (@(posedge clk_32_768) disable iff (reset_turbo_s)
    clk_en |-> clk_2x_en)
    else begin
      fail_count++;
      $error("2x tick missing on a 1x tick");
    end

  a_halt_gates_ticks: assert property (@(posedge clk_32_768) disable iff (reset_turbo_s)
    halt |-> !clk_en && !clk_2x_en)
    else begin
      fail_count++;
      $error("CPU clock enable seen while halted");
    end

  a_halt_holds_rom_data: assert property (@(posedge clk_32_768) disable iff (reset_turbo_s)
    halt && $past(halt) |-> $stable(rom_data))
    else begin
      fail_count++;
      $error("rom_data changed while halted");
    end

endmodule

bind tamago_core_top tamago_props i_tamago_props (
  .clk_32_768    (clk_32_768),
  .reset_turbo_s (reset_turbo_s),
  .halt          (halt),
  .clk_en        (clk_en),
  .clk_2x_en     (clk_2x_en),
  .rom_data      (rom_data),
  .tick          (tick),
  .tick_2x       (tick_2x),
  .speed         (settings.speed)
);

// ==== src/tamago_core_top.sv ====
// tamago control core top
// bus settings slave, CPU tick generator, program ROM and CPU port

`timescale 1ns/10ps
`include "tamago_settings.svh"

module tamago_core_top (
  input  logic                        clk_32_768,
  input  logic                        reset_turbo_s,
  input  tamago_bus_pkg::axil_req_t   axil_req,
  output tamago_bus_pkg::axil_rsp_t   axil_rsp,
  input  logic                        buzzer,
  input  logic                        halt,
  input  logic [`TAMAGO_ROM_AW-1:0]   rom_addr,
  output logic                        clk_en,
  output logic                        clk_2x_en,
  output logic [11:0]                 rom_data,
  output logic [`TAMAGO_AUDIO_W-1:0]  audio_level
);

  tamago_core_pkg::settings_t settings;
  tamago_bus_pkg::rom_wr_t    rom_wr;
  logic                       tick;
  logic                       tick_2x;
  logic [15:0]                rom_word;

  bridge_settings i_bridge_settings (
    .clk_32_768    (clk_32_768),
    .reset_turbo_s (reset_turbo_s),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .buzzer        (buzzer),
    .settings      (settings),
    .rom_wr        (rom_wr),
    .audio_level   (audio_level)
  );

  cpu_tick_gen i_cpu_tick_gen (
    .clk_32_768    (clk_32_768),
    .reset_turbo_s (reset_turbo_s),
    .speed         (settings.speed),
    .tick          (tick),
    .tick_2x       (tick_2x)
  );

  rom_image i_rom_image (
    .clk_32_768 (clk_32_768),
    .rom_wr     (rom_wr),
    .rd_addr    (rom_addr),
    .rd_data    (rom_word)
  );

  core_port i_core_port (
    .clk_32_768    (clk_32_768),
    .reset_turbo_s (reset_turbo_s),
    .tick          (tick),
    .tick_2x       (tick_2x),
    .halt          (halt),
    .rom_word      (rom_word),
    .clk_en        (clk_en),
    .clk_2x_en     (clk_2x_en),
    .rom_data      (rom_data)
  );

endmodule

// ==== src/core_port.sv ====
// CPU side port
// gates the ticks with halt and samples ROM data on delivered ticks only

`timescale 1ns/10ps

module core_port (
  input  logic        clk_32_768,
  input  logic        reset_turbo_s,
  input  logic        tick,
  input  logic        tick_2x,
  input  logic        halt,
  input  logic [15:0] rom_word,
  output logic        clk_en,
  output logic        clk_2x_en,
  output logic [11:0] rom_data
);

  // CPU sees no ticks while halted
  assign clk_en    = tick && !halt;
  assign clk_2x_en = tick_2x && !halt;

  // instruction words are 12 bits wide
  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      rom_data <= '0;
    end else if (clk_en) begin
      rom_data <= rom_word[11:0];
    end
  end

endmodule

// ==== src/rom_image.sv ====
// program ROM image
// 16-bit word store, loaded over the bus, read by the CPU side
// one cycle read latency, read returns the old word on a collision

`timescale 1ns/10ps
`include "tamago_settings.svh"

module rom_image (
  input  logic                       clk_32_768,
  input  tamago_bus_pkg::rom_wr_t    rom_wr,
  input  logic [`TAMAGO_ROM_AW-1:0]  rd_addr,
  output logic [15:0]                rd_data
);

  logic [15:0] mem [`TAMAGO_ROM_WORDS];

  // load port
  always_ff @(posedge clk_32_768) begin
    if (rom_wr.en) begin
      mem[rom_wr.addr] <= rom_wr.data;
    end
  end

  // registered read
  always_ff @(posedge clk_32_768) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== src/cpu_tick_gen.sv ====
// CPU tick generator
// turbo dependent down-counter giving the 1x and 2x CPU clock enables

`timescale 1ns/10ps
`include "tamago_settings.svh"

module cpu_tick_gen (
  input  logic                          clk_32_768,
  input  logic                          reset_turbo_s,
  input  tamago_core_pkg::turbo_speed_t speed,
  output logic                          tick,
  output logic                          tick_2x
);

  logic [`TAMAGO_DIV_W-1:0] reload;
  logic [`TAMAGO_DIV_W-1:0] count;

  // reload per speed, max shares the 50x rate
  always_comb begin
    case (speed)
      tamago_core_pkg::SPEED_1X:  reload = `TAMAGO_DIV_1X;
      tamago_core_pkg::SPEED_4X:  reload = `TAMAGO_DIV_4X;
      tamago_core_pkg::SPEED_50X: reload = `TAMAGO_DIV_50X;
      default:                    reload = `TAMAGO_DIV_50X;
    endcase
  end

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      count   <= `TAMAGO_DIV_1X;
      tick    <= 1'b0;
      tick_2x <= 1'b0;
    end else begin
      tick    <= 1'b0;
      tick_2x <= 1'b0;
      if (count == '0) begin
        // new speed only picked up here
        count   <= reload;
        tick    <= 1'b1;
        tick_2x <= 1'b1;
      end else begin
        count <= count - 1'b1;
        // mid-period half tick
        if (count == (reload >> 1)) begin
          tick_2x <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/bridge_settings.sv ====
// bridge settings slave
// AXI4-Lite registers for mute, turbo speed and turbo cancel,
// ROM load routing with byte swap, and the muted buzzer level

`timescale 1ns/10ps
`include "tamago_settings.svh"

module bridge_settings (
  input  logic                        clk_32_768,
  input  logic                        reset_turbo_s,
  input  tamago_bus_pkg::axil_req_t   axil_req,
  output tamago_bus_pkg::axil_rsp_t   axil_rsp,
  input  logic                        buzzer,
  output tamago_core_pkg::settings_t  settings,
  output tamago_bus_pkg::rom_wr_t     rom_wr,
  output logic [`TAMAGO_AUDIO_W-1:0]  audio_level
);

  tamago_core_pkg::settings_t settings_q;
  logic        wr_accept;
  logic        rd_accept;
  logic        rom_region;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // write needs both channels and a free B slot
  assign wr_accept  = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_accept  = axil_req.arvalid && !rvalid_q;
  assign rom_region = axil_req.awaddr[31:28] == 4'(`TAMAGO_ROM_BASE >> 28);

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = 2'b00;
  end

  ////////////////////////////////////////////////////
  // response channels

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_accept) begin
        rvalid_q <= 1'b1;
        // only the speed is readable
        if (axil_req.araddr == `TAMAGO_REG_TURBO) begin
          rdata_q <= {30'b0, settings_q.speed};
        end else begin
          rdata_q <= '0;
        end
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      settings_q <= '0;
    end else begin
      if (wr_accept && axil_req.wstrb[0]) begin
        case (axil_req.awaddr)
          `TAMAGO_REG_SOUND:  settings_q.mute <= axil_req.wdata[0];
          `TAMAGO_REG_TURBO:  settings_q.speed <=
              tamago_core_pkg::turbo_speed_t'(axil_req.wdata[1:0]);
          `TAMAGO_REG_CANCEL: settings_q.cancel_on_buzzer <= axil_req.wdata[0];
          default: ;
        endcase
      end
      // buzzer drops turbo, beats a bus write in the same cycle
      if (settings_q.cancel_on_buzzer && buzzer) begin
        settings_q.speed <= tamago_core_pkg::SPEED_1X;
      end
    end
  end

  assign settings = settings_q;

  // ROM words arrive big endian
  assign rom_wr.en   = wr_accept && rom_region && (&axil_req.wstrb[1:0]);
  assign rom_wr.addr = axil_req.awaddr[13:1];
  assign rom_wr.data = {axil_req.wdata[7:0], axil_req.wdata[15:8]};

  // buzzer level, one cycle behind
  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      audio_level <= '0;
    end else if (buzzer && !settings_q.mute) begin
      audio_level <= `TAMAGO_AUDIO_ON;
    end else begin
      audio_level <= '0;
    end
  end

endmodule

// ==== src/tamago_bus_pkg.sv ====
// tamago bus types
// AXI4-Lite channel bundles and the byte-swapped ROM write

`include "tamago_settings.svh"

package tamago_bus_pkg;

  // master driven signals
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axil_req_t;

  // slave driven signals
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // one ROM word write, data already swapped
  typedef struct packed {
    logic                       en;
    logic [`TAMAGO_ROM_AW-1:0]  addr;
    logic [15:0]                data;
  } rom_wr_t;

endpackage

// ==== src/tamago_core_pkg.sv ====
// tamago core types
// turbo speed encoding and the settings bundle

package tamago_core_pkg;

  // max runs at the 50x rate for now
  typedef enum logic [1:0] {
    SPEED_1X  = 2'd0,
    SPEED_4X  = 2'd1,
    SPEED_50X = 2'd2,
    SPEED_MAX = 2'd3
  } turbo_speed_t;

  typedef struct packed {
    logic         mute;
    turbo_speed_t speed;
    logic         cancel_on_buzzer;
  } settings_t;

endpackage

// ==== src/tamago_settings.svh ====
// tamago control core settings
// ROM geometry, CPU clock divider reloads, register map and audio levels

`ifndef TAMAGO_SETTINGS_SVH
`define TAMAGO_SETTINGS_SVH

// program ROM, 16-bit words
`define TAMAGO_ROM_WORDS 8192
`define TAMAGO_ROM_AW 13

// divider reload per turbo speed, tick spacing is reload + 1
`define TAMAGO_DIV_1X 10'd400
`define TAMAGO_DIV_4X 10'd100
`define TAMAGO_DIV_50X 10'd8
`define TAMAGO_DIV_W 10

// settings register byte offsets
`define TAMAGO_REG_SOUND 32'h0000_0010
`define TAMAGO_REG_TURBO 32'h0000_0100
`define TAMAGO_REG_CANCEL 32'h0000_0104

// ROM region, any address with this top nibble
`define TAMAGO_ROM_BASE 32'h1000_0000

// buzzer level
`define TAMAGO_AUDIO_W 15
`define TAMAGO_AUDIO_ON 15'h1FFF

`endif
